//--- hdl/mul_pkg.sv
/*
 shared widths and stage records of the RV32M multiply unit
 widths are fixed by the RV32 ISA, nothing here is meant to be retuned
 */

package mul_pkg;

    // ISA widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 4;

    // multiplier split point, low half of the operand is unsigned
    localparam int SPLIT_W   = 16;
    // 33x16 signed by unsigned
    localparam int PART_LO_W = XLEN + 1 + SPLIT_W;
    // 33x17 signed by signed
    localparam int PART_HI_W = 2 * (XLEN + 1) - SPLIT_W;
    // full product of two 33-bit operands
    localparam int PROD_W    = 2 * (XLEN + 1);

    typedef enum logic [1:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } mul_op_e;

    // sideband carried through every stage
    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] cid;
        // high word select, every op but MUL
        logic                   hi_sel;
    } mul_tag_t;

    // issued request, operands already after the bypass select
    typedef struct packed {
        mul_op_e                op;
        logic [XLEN-1:0]        op1;
        logic [XLEN-1:0]        op2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] cid;
    } mul_req_t;

    // stage 1 output, operands extended to 33 bits
    typedef struct packed {
        logic signed [XLEN:0] a;
        logic signed [XLEN:0] b;
        mul_tag_t             tag;
    } mul_prep_t;

    // stage 2 output, the two partial products
    typedef struct packed {
        logic signed [PART_LO_W-1:0] lo;
        logic signed [PART_HI_W-1:0] hi;
        mul_tag_t                    tag;
    } mul_part_t;

    // write-back record
    typedef struct packed {
        logic [XLEN-1:0]        data;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] cid;
    } mul_wb_t;

endpackage

//--- hdl/mul_issue.sv
/*
 issue front end with a one-entry holding buffer
 a stalled strobe is dropped here, upstream must repeat it next cycle
 kill only suppresses a new issue, it does not flush the buffer
 */

module mul_issue (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              advance_i,
    input  logic                              req_mul_i,
    input  logic                              int_assert_i,
    input  logic                              op_mul_i,
    input  logic                              op_mulh_i,
    input  logic                              op_mulhsu_i,
    input  logic                              op_mulhu_i,
    input  logic [mul_pkg::XLEN-1:0]          reg1_rdata_i,
    input  logic [mul_pkg::XLEN-1:0]          reg2_rdata_i,
    input  logic [mul_pkg::XLEN-1:0]          alu_bypass_i,
    input  logic                              pass_op1_i,
    input  logic                              pass_op2_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]    reg_waddr_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0]   commit_id_i,
    output logic                              mul_stall_o,
    output logic                              req_valid_o,
    output mul_pkg::mul_req_t                 req_o
);

    import mul_pkg::*;

    logic     live;
    mul_op_e  new_op;
    mul_req_t new_req;
    logic     buf_valid;
    mul_req_t buf_req;
    logic     buf_fill;

    // interrupt kills the strobe
    assign live = req_mul_i & ~int_assert_i;

    // one-hot flags to op code
    always_comb begin
        case ({op_mulhu_i, op_mulhsu_i, op_mulh_i, op_mul_i})
            4'b0010: new_op = OP_MULH;
            4'b0100: new_op = OP_MULHSU;
            4'b1000: new_op = OP_MULHU;
            default: new_op = OP_MUL;
        endcase
    end

    // bypass select happens at capture, buffer holds final operands
    always_comb begin
        new_req.op  = new_op;
        new_req.op1 = pass_op1_i ? alu_bypass_i : reg1_rdata_i;
        new_req.op2 = pass_op2_i ? alu_bypass_i : reg2_rdata_i;
        new_req.rd  = reg_waddr_i;
        new_req.cid = commit_id_i;
    end

    // full and draining, or empty and blocked
    assign buf_fill = live & (buf_valid == advance_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (buf_valid && advance_i) begin
            // buffered item leaves, a new one may take its place
            buf_valid <= live;
        end else if (buf_fill) begin
            buf_valid <= 1'b1;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (buf_fill) begin
            buf_req <= new_req;
        end
    end

    // buffer always goes first to keep issue order
    assign req_valid_o = buf_valid | live;
    assign req_o       = buf_valid ? buf_req : new_req;

    // full, blocked and another live issue, that one is refused
    assign mul_stall_o = buf_valid & live & ~advance_i;

    a_op_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        req_mul_i |-> $onehot({op_mul_i, op_mulh_i, op_mulhsu_i, op_mulhu_i}));

    // a full buffer keeps its item while the pipe is blocked
    a_buf_hold: assert property (@(posedge clk) disable iff (!rst_n)
        buf_valid && !advance_i |=> buf_valid && $stable(buf_req));

endmodule

//--- hdl/mul_operand_prep.sv
/*
 stage 1, extends both operands to 33 bits
 sign rules follow RV32M, MULHU and MUL use zero extension
 */

module mul_operand_prep (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance_i,
    input  logic               valid_i,
    input  mul_pkg::mul_req_t  req_i,
    output logic               valid_o,
    output mul_pkg::mul_prep_t prep_o
);

    import mul_pkg::*;

    logic      sign1;
    logic      sign2;
    mul_prep_t prep_d;

    // op1 signed for MULH and MULHSU
    assign sign1 = (req_i.op == OP_MULH) | (req_i.op == OP_MULHSU);
    // op2 signed for MULH only
    assign sign2 = (req_i.op == OP_MULH);

    always_comb begin
        // extra top bit is the sign or zero
        prep_d.a = {sign1 & req_i.op1[XLEN-1], req_i.op1};
        prep_d.b = {sign2 & req_i.op2[XLEN-1], req_i.op2};
        prep_d.tag.rd     = req_i.rd;
        prep_d.tag.cid    = req_i.cid;
        // low word only for plain MUL
        prep_d.tag.hi_sel = (req_i.op != OP_MUL);
    end

    // stage valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (advance_i) begin
            prep_o <= prep_d;
        end
    end

endmodule

//--- hdl/mul_partial.sv
/*
 stage 2, two partial products from a split multiplier
 low part treats b[15:0] as unsigned, high part b[32:16] as signed
 */

module mul_partial (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance_i,
    input  logic               valid_i,
    input  mul_pkg::mul_prep_t prep_i,
    output logic               valid_o,
    output mul_pkg::mul_part_t part_o
);

    import mul_pkg::*;

    logic signed [XLEN:0]         mcand;
    // zero extended low half of the multiplier
    logic signed [SPLIT_W:0]      mplier_lo;
    // signed upper 17 bits
    logic signed [XLEN-SPLIT_W:0] mplier_hi;
    logic signed [PART_LO_W-1:0]  lo_prod;
    logic signed [PART_HI_W-1:0]  hi_prod;
    mul_part_t                    part_d;

    assign mcand     = prep_i.a;
    assign mplier_lo = $signed({1'b0, prep_i.b[SPLIT_W-1:0]});
    assign mplier_hi = $signed(prep_i.b[XLEN:SPLIT_W]);

    // both fit their widths without overflow
    assign lo_prod = mcand * mplier_lo;
    assign hi_prod = mcand * mplier_hi;

    always_comb begin
        part_d.lo  = lo_prod;
        part_d.hi  = hi_prod;
        part_d.tag = prep_i.tag;
    end

    // stage valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (advance_i) begin
            part_o <= part_d;
        end
    end

    // a blocked pipe neither drops nor creates items in the middle stage
    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !advance_i |=> $stable(valid_o));

endmodule

//--- hdl/mul_combine.sv
/*
 stage 3, sums the partials and drives the write-back record
 the record holds while write-back is blocked
 */

module mul_combine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance_i,
    input  logic               valid_i,
    input  mul_pkg::mul_part_t part_i,
    output logic               valid_o,
    output mul_pkg::mul_wb_t   wb_o
);

    import mul_pkg::*;

    logic signed [PROD_W-1:0] prod;
    logic [XLEN-1:0]          word;
    mul_wb_t                  wb_d;

    // lo + (hi << 16), both sign extended to the full product width
    assign prod = part_i.lo + (part_i.hi <<< SPLIT_W);

    // high or low word of the 64-bit result
    assign word = part_i.tag.hi_sel ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

    always_comb begin
        wb_d.data = word;
        wb_d.rd   = part_i.tag.rd;
        wb_d.cid  = part_i.tag.cid;
    end

    // stage valid, doubles as register write enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (advance_i) begin
            wb_o <= wb_d;
        end
    end

    // held result must reach write-back unchanged
    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && !advance_i |=> valid_o && $stable(wb_o));

endmodule

//--- hdl/mul_unit_top.sv
/*
 RV32M multiply unit, issue buffer plus three-stage pipeline
 latency is 3 cycles without back-pressure, results leave in issue order
 */

module mul_unit_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wb_ready_i,
    input  logic                            req_mul_i,
    input  logic                            op_mul_i,
    input  logic                            op_mulh_i,
    input  logic                            op_mulhsu_i,
    input  logic                            op_mulhu_i,
    input  logic [mul_pkg::XLEN-1:0]        reg1_rdata_i,
    input  logic [mul_pkg::XLEN-1:0]        reg2_rdata_i,
    input  logic [mul_pkg::XLEN-1:0]        alu_bypass_i,
    input  logic                            pass_op1_i,
    input  logic                            pass_op2_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] commit_id_i,
    input  logic                            int_assert_i,
    output logic                            mul_stall_o,
    output logic                            reg_we_o,
    output mul_pkg::mul_wb_t                wb_o
);

    import mul_pkg::*;

    logic      advance;
    logic      req_valid;
    mul_req_t  req;
    logic      prep_valid;
    mul_prep_t prep;
    logic      part_valid;
    mul_part_t part;
    logic      comb_valid;

    // whole pipe freezes only when a finished result is not taken
    assign advance  = ~(comb_valid & ~wb_ready_i);
    assign reg_we_o = comb_valid;

    mul_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .advance_i    (advance),
        .req_mul_i    (req_mul_i),
        .int_assert_i (int_assert_i),
        .op_mul_i     (op_mul_i),
        .op_mulh_i    (op_mulh_i),
        .op_mulhsu_i  (op_mulhsu_i),
        .op_mulhu_i   (op_mulhu_i),
        .reg1_rdata_i (reg1_rdata_i),
        .reg2_rdata_i (reg2_rdata_i),
        .alu_bypass_i (alu_bypass_i),
        .pass_op1_i   (pass_op1_i),
        .pass_op2_i   (pass_op2_i),
        .reg_waddr_i  (reg_waddr_i),
        .commit_id_i  (commit_id_i),
        .mul_stall_o  (mul_stall_o),
        .req_valid_o  (req_valid),
        .req_o        (req)
    );

    mul_operand_prep u_prep (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (advance),
        .valid_i   (req_valid),
        .req_i     (req),
        .valid_o   (prep_valid),
        .prep_o    (prep)
    );

    mul_partial u_part (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (advance),
        .valid_i   (prep_valid),
        .prep_i    (prep),
        .valid_o   (part_valid),
        .part_o    (part)
    );

    mul_combine u_comb (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (advance),
        .valid_i   (part_valid),
        .part_i    (part),
        .valid_o   (comb_valid),
        .wb_o      (wb_o)
    );

endmodule

//--- test/tb_mul_unit.sv
/*
 random testbench for the RV32M multiply unit
 expected words come from a 64-bit reference product, order from a queue
 a cycle model of buffer and stage occupancy predicts stall and write enable
 */

module tb_mul_unit;

    import mul_pkg::*;

    localparam int N_STEADY   = 120;
    localparam int N_RANDOM   = 280;
    // a few cycles per issue at worst, plus reset and drain slack
    localparam int MAX_CYCLES = (N_STEADY + N_RANDOM) * 9 + 400;

    localparam int OPC_MUL    = 0;
    localparam int OPC_MULH   = 1;
    localparam int OPC_MULHSU = 2;
    localparam int OPC_MULHU  = 3;

    // one expected write-back
    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  rd;
        logic [3:0]  cid;
        logic        chk_lat;
        int          issue_cyc;
    } exp_rec_t;

    logic        clk;
    logic        rst_n;
    logic        wb_ready_i;
    logic        req_mul_i;
    logic        op_mul_i;
    logic        op_mulh_i;
    logic        op_mulhsu_i;
    logic        op_mulhu_i;
    logic [31:0] reg1_rdata_i;
    logic [31:0] reg2_rdata_i;
    logic [31:0] alu_bypass_i;
    logic        pass_op1_i;
    logic        pass_op2_i;
    logic [4:0]  reg_waddr_i;
    logic [3:0]  commit_id_i;
    logic        int_assert_i;
    logic        mul_stall_o;
    logic        reg_we_o;
    mul_wb_t     wb_o;

    logic [31:0] rng;
    logic [31:0] r;
    int          cyc = 0;
    int          cur_op;
    int          n_issued;
    logic [3:0]  cid_cnt;
    logic        steady;
    exp_rec_t    exp_q[$];

    // monitor state
    int          n_mismatch = 0;
    int          n_other = 0;
    int          n_stalls = 0;
    int          n_kills = 0;
    logic        retry = 1'b0;
    logic        prev_hold = 1'b0;
    mul_wb_t     prev_wb;
    logic        live;
    logic        adv;
    logic        exp_stall;
    logic [31:0] op_a;
    logic [31:0] op_b;
    exp_rec_t    rec;
    // occupancy model, buffer then stages 1 to 3
    logic        m_buf = 1'b0;
    logic        m_v1 = 1'b0;
    logic        m_v2 = 1'b0;
    logic        m_v3 = 1'b0;

    mul_unit_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_ready_i   (wb_ready_i),
        .req_mul_i    (req_mul_i),
        .op_mul_i     (op_mul_i),
        .op_mulh_i    (op_mulh_i),
        .op_mulhsu_i  (op_mulhsu_i),
        .op_mulhu_i   (op_mulhu_i),
        .reg1_rdata_i (reg1_rdata_i),
        .reg2_rdata_i (reg2_rdata_i),
        .alu_bypass_i (alu_bypass_i),
        .pass_op1_i   (pass_op1_i),
        .pass_op2_i   (pass_op2_i),
        .reg_waddr_i  (reg_waddr_i),
        .commit_id_i  (commit_id_i),
        .int_assert_i (int_assert_i),
        .mul_stall_o  (mul_stall_o),
        .reg_we_o     (reg_we_o),
        .wb_o         (wb_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // cycle count and hard stop
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // one in four is a corner value
    function automatic logic [31:0] pick_operand();
        logic [31:0] sel;
        logic [31:0] val;
        sel = next_rand();
        val = next_rand();
        case (sel[3:0])
            4'd0: return 32'h0000_0000;
            4'd1: return 32'h0000_0001;
            4'd2: return 32'hffff_ffff;
            4'd3: return 32'h8000_0000;
            default: return val;
        endcase
    endfunction

    // RV32M result word from the full 64-bit product
    function automatic logic [31:0] ref_mul(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea = {32'h0, a};
        eb = {32'h0, b};
        // rs1 signed for MULH and MULHSU
        if ((op == OPC_MULH || op == OPC_MULHSU) && a[31]) begin
            ea[63:32] = 32'hffff_ffff;
        end
        // rs2 signed for MULH only
        if (op == OPC_MULH && b[31]) begin
            eb[63:32] = 32'hffff_ffff;
        end
        // low 64 bits are exact for the extended operands
        prod = ea * eb;
        if (op == OPC_MUL) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    // one cycle of stimulus, 1 unit after the edge
    task automatic drive_cycle(input logic want_req, input logic ready);
        logic [31:0] s;
        @(posedge clk);
        #1;
        wb_ready_i = ready;
        if (retry) begin
            // refused strobe goes again unchanged
            req_mul_i = 1'b1;
        end else begin
            s = next_rand();
            cur_op       = int'(s[1:0]);
            op_mul_i     = (cur_op == OPC_MUL);
            op_mulh_i    = (cur_op == OPC_MULH);
            op_mulhsu_i  = (cur_op == OPC_MULHSU);
            op_mulhu_i   = (cur_op == OPC_MULHU);
            req_mul_i    = want_req;
            // about one in eight killed
            int_assert_i = (s[4:2] == 3'd0);
            pass_op1_i   = (s[6:5] == 2'd0);
            pass_op2_i   = (s[8:7] == 2'd0);
            reg_waddr_i  = s[13:9];
            reg1_rdata_i = pick_operand();
            reg2_rdata_i = pick_operand();
            alu_bypass_i = pick_operand();
            if (want_req) begin
                cid_cnt = cid_cnt + 4'd1;
                n_issued++;
            end
            commit_id_i = cid_cnt;
        end
    endtask

    // checker and occupancy model, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            if (reg_we_o || mul_stall_o) begin
                $display("error at %0t: write enable or stall active in reset", $time);
                n_other++;
            end
        end else begin
            live      = req_mul_i && !int_assert_i;
            adv       = !(m_v3 && !wb_ready_i);
            exp_stall = m_buf && live && !adv;
            if (mul_stall_o !== exp_stall) begin
                $display("MISMATCH at %0t: stall %b, expected %b",
                         $time, mul_stall_o, exp_stall);
                n_mismatch++;
            end
            if (reg_we_o !== m_v3) begin
                $display("MISMATCH at %0t: reg_we %b, expected %b", $time, reg_we_o, m_v3);
                n_mismatch++;
            end
            // blocked record must not move
            if (prev_hold && wb_o !== prev_wb) begin
                $display("MISMATCH at %0t: wb record changed while blocked", $time);
                n_mismatch++;
            end
            if (reg_we_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: result with no request outstanding", $time);
                    n_other++;
                end else begin
                    rec = exp_q.pop_front();
                    if (wb_o.data !== rec.data || wb_o.rd !== rec.rd ||
                        wb_o.cid !== rec.cid) begin
                        $display("MISMATCH at %0t: data/rd/cid %h/%0d/%0d, expected %h/%0d/%0d",
                                 $time, wb_o.data, wb_o.rd, wb_o.cid, rec.data, rec.rd, rec.cid);
                        n_mismatch++;
                    end
                    if (rec.chk_lat && (cyc - rec.issue_cyc) != 3) begin
                        $display("MISMATCH at %0t: latency %0d cycles, expected 3",
                                 $time, cyc - rec.issue_cyc);
                        n_mismatch++;
                    end
                end
            end
            prev_hold = reg_we_o && !wb_ready_i;
            prev_wb   = wb_o;
            if (req_mul_i && int_assert_i) begin
                n_kills++;
            end
            if (mul_stall_o) begin
                n_stalls++;
            end
            // accepted strobe, operands after the bypass select
            if (live && !mul_stall_o) begin
                op_a = pass_op1_i ? alu_bypass_i : reg1_rdata_i;
                op_b = pass_op2_i ? alu_bypass_i : reg2_rdata_i;
                rec.data      = ref_mul(cur_op, op_a, op_b);
                rec.rd        = reg_waddr_i;
                rec.cid       = commit_id_i;
                rec.chk_lat   = steady;
                rec.issue_cyc = cyc;
                exp_q.push_back(rec);
            end
            retry = mul_stall_o;
            // state after the coming edge
            if (adv) begin
                m_v3  = m_v2;
                m_v2  = m_v1;
                m_v1  = m_buf || live;
                m_buf = m_buf && live;
            end else if (!m_buf && live) begin
                m_buf = 1'b1;
            end
        end
    end

    initial begin
        rng          = 32'h8fbe;
        rst_n        = 1'b0;
        wb_ready_i   = 1'b1;
        req_mul_i    = 1'b0;
        op_mul_i     = 1'b1;
        op_mulh_i    = 1'b0;
        op_mulhsu_i  = 1'b0;
        op_mulhu_i   = 1'b0;
        reg1_rdata_i = 32'h0;
        reg2_rdata_i = 32'h0;
        alu_bypass_i = 32'h0;
        pass_op1_i   = 1'b0;
        pass_op2_i   = 1'b0;
        reg_waddr_i  = 5'd0;
        commit_id_i  = 4'd0;
        int_assert_i = 1'b0;
        cid_cnt      = 4'd0;
        cur_op       = OPC_MUL;
        n_issued     = 0;
        steady       = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // write-back always ready, fixed latency expected
        while (n_issued < N_STEADY) begin
            r = next_rand();
            drive_cycle(r[1:0] != 2'd0, 1'b1);
        end
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, 1'b1);
        end
        steady = 1'b0;

        // random back-pressure with dense issue
        while (n_issued < N_STEADY + N_RANDOM) begin
            r = next_rand();
            if (r[7:4] == 4'd0) begin
                // long block fills stages and buffer
                repeat (6) drive_cycle(1'b1, 1'b0);
            end else begin
                drive_cycle(r[1:0] != 2'd3, r[3:2] != 2'd0);
            end
        end
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, 1'b1);
        end
        // idle tail catches stray results
        repeat (4) drive_cycle(1'b0, 1'b1);
        @(negedge clk);

        $display(
            "done: %0d issued, %0d stalls, %0d kills, %0d mismatch, %0d other err, %0d missing",
            n_issued, n_stalls, n_kills, n_mismatch, n_other, exp_q.size());
        if (n_mismatch + n_other + exp_q.size() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- mul_unit.f
hdl/mul_pkg.sv
hdl/mul_issue.sv
hdl/mul_operand_prep.sv
hdl/mul_partial.sv
hdl/mul_combine.sv
hdl/mul_unit_top.sv
test/tb_mul_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the multiply unit testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mul_unit -f mul_unit.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_mul_unit)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
